/* hwpe_stream_engine.f */
src/hwpe_stream_pkg.sv
src/hwpe_ctrl_pkg.sv
src/hwpe_fifo_earlystall.sv
src/hwpe_scale_stage.sv
src/hwpe_beat_counter.sv
src/hwpe_job_fsm.sv
src/hwpe_stream_engine.sv
bench/hwpe_engine_checker.sv
bench/tb_hwpe_stream_engine.sv

/* bench/tb_hwpe_stream_engine.sv */
`timescale 1ns/1ns

module tb_hwpe_stream_engine;

  localparam int n_jobs = 12;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   start;
  hwpe_ctrl_pkg::job_cfg_t                cfg;
  logic                                   busy;
  logic                                   done;
  logic [hwpe_stream_pkg::data_width-1:0] in_data;
  logic                                   in_valid;
  logic                                   in_grant;
  hwpe_stream_pkg::stream_beat_t          out_beat;
  logic                                   out_valid;
  logic                                   out_grant;
  int                                     value_errors;
  int                                     other_errors;

  logic [31:0]             lfsr = 32'hb6b8_9d34;
  hwpe_ctrl_pkg::job_cfg_t jobs [n_jobs];
  int                      total_words = 0;
  logic                    jobs_ready = 1'b0;
  // sink held off at the start to fill both fifos
  logic                    hold_stall = 1'b1;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  hwpe_stream_engine hwpe_stream_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .busy      (busy),
    .done      (done),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_grant  (in_grant),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_grant (out_grant)
  );

  hwpe_engine_checker chk_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .cfg          (cfg),
    .busy         (busy),
    .done         (done),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_grant     (in_grant),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .out_grant    (out_grant),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : job_sequence
    int end_errors;
    start = 1'b0;
    cfg = '0;
    in_valid = 1'b0;
    in_data = '0;
    out_grant = 1'b0;
    rst_n = 1'b0;
    for (int j = 0; j < n_jobs; j++) begin
      jobs[j].len = 16'(take_bits(5) % 32'd21);
      jobs[j].scale = 16'(take_bits(16));
      jobs[j].offset = take_bits(32);
    end
    // first job longer than the buffers, one job empty
    jobs[0].len = 16'd20;
    jobs[5].len = 16'd0;
    for (int j = 0; j < n_jobs; j++) begin
      total_words += int'(jobs[j].len);
    end
    jobs_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int j = 0; j < n_jobs; j++) begin
      @(posedge clk);
      #1;
      start = 1'b1;
      cfg = jobs[j];
      @(posedge clk);
      #1;
      start = 1'b0;
      if (j == 0) begin
        repeat (40) @(negedge clk);
        hold_stall = 1'b0;
      end
      @(negedge clk);
      while (!done) @(negedge clk);
    end
    repeat (10) @(posedge clk);
    end_errors = chk_i.drain_problems();
    #1;
    $display("closing report: %0d value errors, %0d other errors",
             value_errors, other_errors + end_errors);
    if (value_errors + other_errors + end_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // producer and sink, one lfsr draw order per cycle
  initial begin : stream_drive
    int   sent;
    logic in_fire;
    sent = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      in_fire = in_valid & in_grant;
      @(posedge clk);
      #1;
      if (in_fire) begin
        sent++;
      end
      // valid and data held until taken
      if (!in_valid || in_fire) begin
        if (sent < total_words && take_bits(2) != 0) begin
          in_valid = 1'b1;
          in_data = take_bits(32);
        end else begin
          in_valid = 1'b0;
        end
      end
      out_grant = !hold_stall && (take_bits(2) != 0);
    end
  end

  initial begin : watchdog
    int limit;
    wait (jobs_ready);
    limit = total_words * 40 + n_jobs * 50 + 200;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, job sequence did not finish", limit);
    $display("tests failed");
    $finish;
  end

endmodule

/* bench/hwpe_engine_checker.sv */
`timescale 1ns/1ns

module hwpe_engine_checker (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start,
  input  hwpe_ctrl_pkg::job_cfg_t                cfg,
  input  logic                                   busy,
  input  logic                                   done,
  input  logic [hwpe_stream_pkg::data_width-1:0] in_data,
  input  logic                                   in_valid,
  input  logic                                   in_grant,
  input  hwpe_stream_pkg::stream_beat_t          out_beat,
  input  logic                                   out_valid,
  input  logic                                   out_grant,
  output int                                     value_errors,
  output int                                     other_errors
);

  // in fifo + stage register + out fifo
  localparam int max_held = 2 * hwpe_stream_pkg::fifo_depth + 1;

  // words accepted at the input and not yet seen at the output
  logic [31:0]             in_q [$];
  // started jobs with at least one word
  hwpe_ctrl_pkg::job_cfg_t job_q [$];
  int                      word_idx = 0;
  int                      starts = 0;
  int                      dones = 0;
  int                      value_cnt = 0;
  int                      other_cnt = 0;
  logic                    exp_done = 1'b0;
  logic                    exp_busy = 1'b0;
  logic                    after_reset = 1'b0;

  assign value_errors = value_cnt;
  assign other_errors = other_cnt;

  // expected word is data times scale plus offset modulo 2^32
  function automatic logic [31:0] scale_offset(input logic [31:0] data,
                                               input logic [15:0] scale,
                                               input logic [31:0] offset);
    logic [63:0] full;
    full = {32'd0, data} * {48'd0, scale} + {32'd0, offset};
    return full[31:0];
  endfunction

  // sampled mid-cycle before the rising edge that moves a word
  always @(negedge clk) begin : compare
    logic [31:0]             expected;
    logic                    exp_last;
    logic                    next_done;
    logic                    next_busy;
    hwpe_ctrl_pkg::job_cfg_t job;
    next_done = 1'b0;
    next_busy = exp_busy;
    if (!rst_n) begin
      after_reset = 1'b1;
      next_busy = 1'b0;
    end else begin
      if (after_reset) begin
        after_reset = 1'b0;
        if (busy || done || out_valid || !in_grant) begin
          $display("%0t ns: engine not idle after reset", $time);
          other_cnt++;
        end
      end
      // done one cycle after the final transfer or an empty start
      if (done !== exp_done) begin
        $display("** Error at %0t ns: done expected %b, got %b", $time, exp_done, done);
        value_cnt++;
      end
      // busy from the cycle after start until the final transfer
      if (busy !== exp_busy) begin
        $display("** Error at %0t ns: busy expected %b, got %b", $time, exp_busy, busy);
        value_cnt++;
      end
      if (done) begin
        dones++;
      end
      // the engine can never hold more than its buffers
      if (in_q.size() > max_held) begin
        $display("%0t ns: %0d words taken in, more than the buffers can hold",
                 $time, in_q.size());
        other_cnt++;
      end
      // start only counts when idle
      if (start && !exp_busy && !exp_done) begin
        starts++;
        if (cfg.len == '0) begin
          next_done = 1'b1;
        end else begin
          job_q.push_back(cfg);
          next_busy = 1'b1;
        end
      end
      if (out_valid && out_grant) begin
        if (in_q.size() == 0 || job_q.size() == 0) begin
          $display("%0t ns: output beat while expected queue empty", $time);
          other_cnt++;
        end else begin
          job = job_q[0];
          expected = scale_offset(in_q.pop_front(), job.scale, job.offset);
          exp_last = (word_idx + 1 == int'(job.len));
          if (out_beat.data !== expected) begin
            $display("** Error at %0t ns: out_beat.data expected %h, got %h",
                     $time, expected, out_beat.data);
            value_cnt++;
          end
          if (out_beat.last !== exp_last) begin
            $display("** Error at %0t ns: out_beat.last expected %b, got %b",
                     $time, exp_last, out_beat.last);
            value_cnt++;
          end
          if (exp_last) begin
            next_done = 1'b1;
            next_busy = 1'b0;
            word_idx = 0;
            void'(job_q.pop_front());
          end else begin
            word_idx++;
          end
        end
      end
      // pushed after the output pop so the queue keeps arrival order
      if (in_valid && in_grant) begin
        in_q.push_back(in_data);
      end
    end
    exp_done = next_done;
    exp_busy = next_busy;
  end

  // leftovers at the end of the run give the problem count
  function automatic int drain_problems();
    int problems;
    problems = 0;
    if (in_q.size() != 0 || job_q.size() != 0) begin
      $display("words missing at end of run: %0d input words, %0d jobs unfinished",
               in_q.size(), job_q.size());
      problems++;
    end
    if (dones != starts) begin
      $display("done pulsed %0d times for %0d started jobs", dones, starts);
      problems++;
    end
    return problems;
  endfunction

endmodule

/* src/hwpe_stream_engine.sv */
`timescale 1ns/1ns

module hwpe_stream_engine (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // control
  input  logic                                   start,
  input  hwpe_ctrl_pkg::job_cfg_t                cfg,
  output logic                                   busy,
  output logic                                   done,
  // input stream
  input  logic [hwpe_stream_pkg::data_width-1:0] in_data,
  input  logic                                   in_valid,
  output logic                                   in_grant,
  // output stream
  output hwpe_stream_pkg::stream_beat_t          out_beat,
  output logic                                   out_valid,
  input  logic                                   out_grant
);

  // incoming word as a beat, last filled in later
  hwpe_stream_pkg::stream_beat_t in_beat;
  // input fifo to stage
  hwpe_stream_pkg::stream_beat_t fifo_beat;
  logic                          fifo_valid;
  logic                          fifo_grant;
  // stage to output fifo
  hwpe_stream_pkg::stream_beat_t stage_beat;
  logic                          stage_valid;
  logic                          stage_grant;
  // control side
  hwpe_ctrl_pkg::job_cfg_t       job;
  logic                          take;
  logic                          in_last;
  logic                          exhausted;
  logic                          clear;
  logic                          enable;

  assign in_beat = '{data: in_data, last: 1'b0};

  hwpe_fifo_earlystall #(
    .depth (hwpe_stream_pkg::fifo_depth)
  ) in_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (in_beat),
    .valid_in  (in_valid),
    .grant_out (in_grant),
    .data_out  (fifo_beat),
    .valid_out (fifo_valid),
    .grant_in  (fifo_grant)
  );

  hwpe_scale_stage scale_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .scale     (job.scale),
    .offset    (job.offset),
    .in_last   (in_last),
    .in_beat   (fifo_beat),
    .in_valid  (fifo_valid),
    .in_grant  (fifo_grant),
    .take      (take),
    .out_beat  (stage_beat),
    .out_valid (stage_valid),
    .out_grant (stage_grant)
  );

  hwpe_fifo_earlystall #(
    .depth (hwpe_stream_pkg::fifo_depth)
  ) out_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (stage_beat),
    .valid_in  (stage_valid),
    .grant_out (stage_grant),
    .data_out  (out_beat),
    .valid_out (out_valid),
    .grant_in  (out_grant)
  );

  hwpe_beat_counter counter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .take      (take),
    .len       (job.len),
    .in_last   (in_last),
    .exhausted (exhausted)
  );

  hwpe_job_fsm fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .exhausted (exhausted),
    .out_valid (out_valid),
    .out_grant (out_grant),
    .out_last  (out_beat.last),
    .job       (job),
    .clear     (clear),
    .enable    (enable),
    .busy      (busy),
    .done      (done)
  );

endmodule

/* src/hwpe_job_fsm.sv */
`timescale 1ns/1ns

module hwpe_job_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  hwpe_ctrl_pkg::job_cfg_t cfg,
  input  logic                    exhausted,
  // output stream watched for the final transfer
  input  logic                    out_valid,
  input  logic                    out_grant,
  input  logic                    out_last,
  output hwpe_ctrl_pkg::job_cfg_t job,
  output logic                    clear,
  output logic                    enable,
  output logic                    busy,
  output logic                    done
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } job_state_t;

  job_state_t state, state_nxt;

  // last-marked beat leaves the engine
  logic out_fire_last;

  assign out_fire_last = out_valid & out_grant & out_last;

  // start only counts in idle
  assign clear = start & (state == st_idle);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          // empty job skips straight to done
          state_nxt = (cfg.len == '0) ? st_done : st_run;
        end
      end
      st_run: begin
        if (out_fire_last) begin
          state_nxt = st_done;
        end
      end
      st_done: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // config held for the whole job
  always_ff @(posedge clk) begin
    if (clear) begin
      job <= cfg;
    end
  end

  assign busy   = (state == st_run);
  assign done   = (state == st_done);
  // gate the stage once len words are in
  assign enable = busy & ~exhausted;

  // a last beat leaves only in a running job with all its words taken
  assert property (@(posedge clk) disable iff (!rst_n)
    out_fire_last |-> (busy && exhausted))
    else $error("last beat left outside a running job or before the count was reached");

endmodule

/* src/hwpe_beat_counter.sv */
`timescale 1ns/1ns

module hwpe_beat_counter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                clear,
  input  logic                                take,
  input  logic [hwpe_ctrl_pkg::len_width-1:0] len,
  output logic                                in_last,
  output logic                                exhausted
);

  // words taken so far in this job
  logic [hwpe_ctrl_pkg::len_width-1:0] count;

  // clear wins over take
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (take) begin
      count <= count + 1'b1;
    end
  end

  // next word taken is the final one
  // guard len zero, len - 1 would wrap
  assign in_last   = (len != '0) && (count == len - 1'b1);

  // job has all its words
  assign exhausted = (count >= len);

  // controller must close the stage gate once the count is reached
  assert property (@(posedge clk) disable iff (!rst_n)
    take |-> !exhausted)
    else $error("word taken beyond job length");

endmodule

/* src/hwpe_scale_stage.sv */
`timescale 1ns/1ns

module hwpe_scale_stage (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    enable,
  input  logic [hwpe_ctrl_pkg::scale_width-1:0]   scale,
  input  logic [hwpe_stream_pkg::data_width-1:0]  offset,
  input  logic                                    in_last,
  input  hwpe_stream_pkg::stream_beat_t           in_beat,
  input  logic                                    in_valid,
  output logic                                    in_grant,
  output logic                                    take,
  output hwpe_stream_pkg::stream_beat_t           out_beat,
  output logic                                    out_valid,
  input  logic                                    out_grant
);

  localparam int unsigned dw = hwpe_stream_pkg::data_width;
  localparam int unsigned sw = hwpe_ctrl_pkg::scale_width;

  // full width product of data and scale
  logic [dw+sw-1:0] product;
  logic [dw-1:0]    result;

  assign product = in_beat.data * scale;
  // wraps mod 2^32
  assign result  = product[dw-1:0] + offset;

  // accept when enabled and register empty or draining
  assign in_grant = enable & (~out_valid | out_grant);
  assign take     = in_valid & in_grant;

  // valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_grant) begin
      out_valid <= 1'b0;
    end
  end

  // payload with last from the beat counter
  always_ff @(posedge clk) begin
    if (take) begin
      out_beat.data <= result;
      out_beat.last <= in_last;
    end
  end

  // upstream beat must hold until this stage takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && !in_grant) |=> (in_valid && $stable(in_beat)))
    else $error("stage input changed while stalled");

endmodule

/* src/hwpe_fifo_earlystall.sv */
`timescale 1ns/1ns

module hwpe_fifo_earlystall #(
  parameter int unsigned depth = hwpe_stream_pkg::fifo_depth
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // push side
  input  hwpe_stream_pkg::stream_beat_t data_in,
  input  logic                          valid_in,
  output logic                          grant_out,
  // pop side
  output hwpe_stream_pkg::stream_beat_t data_out,
  output logic                          valid_out,
  input  logic                          grant_in
);

  localparam int unsigned addr_width = $clog2(depth);
  // pointers wrap after the highest slot
  localparam logic [addr_width-1:0] last_slot = addr_width'(depth - 1);
  // depth in occupancy width
  localparam logic [addr_width:0] depth_cnt = (addr_width + 1)'(depth);

  typedef enum logic [1:0] {
    st_empty,
    st_middle,
    st_full
  } fifo_state_t;

  fifo_state_t state, state_nxt;

  logic [addr_width-1:0] push_ptr;
  logic [addr_width-1:0] pop_ptr;
  // words held while in middle
  logic [addr_width:0]   used;
  logic                  push;
  logic                  pop;

  // word storage
  hwpe_stream_pkg::stream_beat_t mem [depth];

  // wrapping increment for any depth
  function automatic logic [addr_width-1:0] next_ptr(input logic [addr_width-1:0] ptr);
    if (ptr == last_slot) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // occupancy from the pointer distance
  always_comb begin
    if (push_ptr > pop_ptr) begin
      used = {1'b0, push_ptr} - {1'b0, pop_ptr};
    end else begin
      used = depth_cnt - ({1'b0, pop_ptr} - {1'b0, push_ptr});
    end
  end

  // handshake outputs per state
  always_comb begin
    case (state)
      st_empty: begin
        valid_out = 1'b0;
        grant_out = 1'b1;
      end
      st_middle: begin
        valid_out = 1'b1;
        // two or more free slots grant regardless of the consumer
        // on the last free slot the grant follows the consumer
        grant_out = (used <= depth_cnt - 2'd2) ? 1'b1 : grant_in;
      end
      st_full: begin
        valid_out = 1'b1;
        // only room if a word leaves this cycle
        grant_out = grant_in;
      end
      default: begin
        valid_out = 1'b0;
        grant_out = 1'b0;
      end
    endcase
  end

  // real transfers only
  assign push = valid_in & grant_out;
  assign pop  = valid_out & grant_in;

  always_comb begin
    state_nxt = state;
    case (state)
      st_empty: begin
        if (push) begin
          state_nxt = st_middle;
        end
      end
      st_middle: begin
        if (push && !pop && next_ptr(push_ptr) == pop_ptr) begin
          state_nxt = st_full;
        end else if (pop && !push && next_ptr(pop_ptr) == push_ptr) begin
          state_nxt = st_empty;
        end
      end
      st_full: begin
        // push with pop keeps it full
        if (pop && !push) begin
          state_nxt = st_middle;
        end
      end
      default: state_nxt = st_empty;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_empty;
      push_ptr <= '0;
      pop_ptr  <= '0;
    end else begin
      state <= state_nxt;
      if (push) begin
        push_ptr <= next_ptr(push_ptr);
      end
      if (pop) begin
        pop_ptr <= next_ptr(pop_ptr);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[push_ptr] <= data_in;
    end
  end

  // head of queue read straight from the pop slot
  assign data_out = mem[pop_ptr];

  // a push without a pop never lands on an occupied slot
  assert property (@(posedge clk) disable iff (!rst_n)
    (push && !pop && state != st_empty) |-> (push_ptr != pop_ptr))
    else $error("fifo pushed while full without a pop");

  // meeting pointers outside full mean an empty fifo offering nothing
  assert property (@(posedge clk) disable iff (!rst_n)
    (push_ptr == pop_ptr && state != st_full) |-> !valid_out)
    else $error("fifo offers a word while its pointers meet");

endmodule

/* src/hwpe_ctrl_pkg.sv */
package hwpe_ctrl_pkg;

  // width of a job length, in words
  localparam int unsigned len_width = 16;

  // width of the unsigned scale factor
  localparam int unsigned scale_width = 16;

  // job configuration, sampled on start
  typedef struct packed {
    // number of words in the job
    logic [len_width-1:0]                  len;
    // unsigned multiplier
    logic [scale_width-1:0]                scale;
    // added after the multiply, wraps mod 2^32
    logic [hwpe_stream_pkg::data_width-1:0] offset;
  } job_cfg_t;

endpackage

/* src/hwpe_stream_pkg.sv */
package hwpe_stream_pkg;

  // width of one stream word
  localparam int unsigned data_width = 32;

  // default buffer depth for the input and output fifos
  // fifo module accepts any depth of 4 or more
  localparam int unsigned fifo_depth = 8;

  // one beat on a valid/grant stream
  // data in the upper bits, end-of-job flag in bit 0
  typedef struct packed {
    // payload word
    logic [data_width-1:0] data;
    // final word of a job
    logic                  last;
  } stream_beat_t;

  // note: words entering the engine carry last as zero,
  // the scale stage fills it in from the beat counter

endpackage
